// File: nabp_line.f
+incdir+verilog
verilog/nabp_pkg.sv
verilog/nabp_host_port.sv
verilog/nabp_ramp_filter.sv
verilog/nabp_filtered_ram.sv
verilog/nabp_dual_port_ram.sv
verilog/nabp_backprojector.sv
verilog/nabp_line_top.sv
test/nabp_line_sva.sv
test/nabp_line_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= nabp_line_tb
FILELIST  ?= nabp_line.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

SOURCES := $(wildcard verilog/*.sv verilog/*.svh test/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@test -f $(LOG) || { echo "no log file $(LOG)"; exit 1; }
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/nabp_line_tb.sv
`include "nabp_settings.svh"

module nabp_line_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import nabp_pkg::*;

    localparam int LINE  = `NABP_LINE_SIZE;
    localparam int PIX   = `NABP_PIXELS;
    localparam int LINES = 8;
    // per line: sample and command writes, fill and projection, accumulator reads
    localparam int CYCLE_LIMIT = LINES * (20 * 6 + 40 + 10 * 6) * 2;

    logic     clk = 1'b0;
    logic     reset_n;
    axil_aw_t aw;
    logic     awready;
    axil_w_t  w;
    logic     wready;
    logic     bvalid;
    logic     bready;
    axil_ar_t ar;
    logic     arready;
    axil_r_t  r;
    logic     rready;

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;
    int          writes_sent = 0;
    int          resp_seen = 0;
    logic        long_hold = 1'b0;
    logic [31:0] rng_state = 32'd24;

    // reference model state
    int line_buf [LINE];
    int model_acc [PIX];

    nabp_line_top i_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready)
    );

    bind nabp_line_top nabp_line_sva i_sva (
        .clk        (clk),
        .reset_n    (reset_n),
        .aw         (aw),
        .awready    (awready),
        .w          (w),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .ar         (ar),
        .arready    (arready),
        .r          (r),
        .rready     (rready),
        .fill_kick  (fill_kick),
        .write_en   (write_en),
        .line_ready (line_ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // write responses, counted where both sides are stable
    always @(negedge clk)
    begin
        if (bvalid && bready)
            resp_seen++;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] cmd_word(input int base, input int step,
                                             input bit clr, input bit kick);
        return 32'((base << 4) | (step << 2) | (int'(clr) << 1) | int'(kick));
    endfunction

    // ramp kernel with zero padding on both ends
    function automatic int filtered(input int k);
        int left;
        int right;
        left  = (k > 0) ? line_buf[k-1] : 0;
        right = (k < LINE - 1) ? line_buf[k+1] : 0;
        return 2 * line_buf[k] - left - right;
    endfunction

    task automatic check_value(input string test, input string what,
                               input int expected, input int actual);
        checks++;
        assert (expected == actual)
        else
        begin
            $display("error %s %s: expected %0d, actual %0d", test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic response_delay();
        int n;
        n = long_hold ? 3 : int'(next_random() % 4);
        repeat (n) @(posedge clk);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        aw.addr  <= addr;
        aw.valid <= 1'b1;
        w.data   <= data;
        w.valid  <= 1'b1;
        @(negedge clk);
        while (!awready)
            @(negedge clk);
        checks++;
        assert (wready)
        else
        begin
            $display("write to 0x%h accepted its address without the write data", addr);
            errors++;
        end
        @(posedge clk);
        aw.valid <= 1'b0;
        w.valid  <= 1'b0;
        writes_sent++;
        @(negedge clk);
        while (!bvalid)
            @(negedge clk);
        response_delay();
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        @(negedge clk);
        checks++;
        assert (!bvalid)
        else
        begin
            $display("write to 0x%h kept its response valid after the handshake", addr);
            errors++;
        end
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        ar.addr  <= addr;
        ar.valid <= 1'b1;
        @(negedge clk);
        while (!arready)
            @(negedge clk);
        @(posedge clk);
        ar.valid <= 1'b0;
        @(negedge clk);
        while (!r.valid)
            @(negedge clk);
        data = r.data;
        checks++;
        assert (r.resp == 2'b00)
        else
        begin
            $display("read from 0x%h returned response %0d instead of OKAY", addr, r.resp);
            errors++;
        end
        response_delay();
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // random samples, junk in the upper bits of each word
    task automatic load_line();
        logic [31:0] v;
        int k;
        for (k = 0; k < LINE; k++)
        begin
            v = next_random();
            line_buf[k] = int'($signed(v[7:0]));
            write_reg(8'(4 * k), v);
        end
    endtask

    task automatic wait_idle();
        logic [31:0] d;
        read_reg(8'h40, d);
        while (d[0])
            read_reg(8'h40, d);
    endtask

    task automatic model_line(input int base, input int step);
        int i;
        int idx;
        for (i = 0; i < PIX; i++)
        begin
            idx = base + i * step;
            if (idx < LINE)
                model_acc[i] = model_acc[i] + filtered(idx);
        end
    endtask

    task automatic run_line(input int base, input int step);
        write_reg(8'h40, cmd_word(base, step, 1'b0, 1'b1));
        wait_idle();
        model_line(base, step);
    endtask

    task automatic compare_accs(input string test);
        logic [31:0] d;
        int i;
        for (i = 0; i < PIX; i++)
        begin
            read_reg(8'(8'h80 + 4 * i), d);
            check_value(test, $sformatf("acc[%0d]", i),
                        int'($signed(16'(model_acc[i]))), int'($signed(d)));
        end
    endtask

    task automatic finish_test(input string test, input int errs_before);
        tests++;
        if (errors == errs_before)
            $display("test %s: ok", test);
        else
            $display("test %s: %0d errors", test, errors - errs_before);
    endtask

    initial
    begin
        logic [31:0] d;
        int errs;
        int n;
        int b1;
        int s1;
        int writes_start;
        int resp_start;

        reset_n = 1'b0;
        aw      = '0;
        w       = '0;
        ar      = '0;
        bready  = 1'b0;
        rready  = 1'b0;
        for (n = 0; n < PIX; n++)
            model_acc[n] = 0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        errs = errors;
        read_reg(8'h40, d);
        check_value("reset", "busy", 0, int'(d[0]));
        compare_accs("reset");
        finish_test("reset", errs);

        // left edge includes the zero pad
        errs = errors;
        load_line();
        run_line(0, 1);
        compare_accs("single_line");
        finish_test("single_line", errs);

        errs = errors;
        for (n = 0; n < 4; n++)
        begin
            load_line();
            run_line(int'(next_random() % 20), int'(next_random() % 4));
            compare_accs("random_lines");
        end
        finish_test("random_lines", errs);

        // second kick lands while the first line is still running
        errs = errors;
        load_line();
        b1 = int'(next_random() % 20);
        s1 = int'(next_random() % 4);
        write_reg(8'h40, cmd_word(b1, s1, 1'b0, 1'b1));
        write_reg(8'h40, cmd_word((b1 + 3) % 20, (s1 + 1) % 4, 1'b0, 1'b1));
        wait_idle();
        model_line(b1, s1);
        compare_accs("kick_busy");
        finish_test("kick_busy", errs);

        errs = errors;
        write_reg(8'h40, cmd_word(0, 0, 1'b1, 1'b0));
        for (n = 0; n < PIX; n++)
            model_acc[n] = 0;
        compare_accs("clear");
        load_line();
        run_line(int'(next_random() % 20), int'(next_random() % 4));
        compare_accs("clear");
        finish_test("clear", errs);

        errs = errors;
        long_hold    = 1'b1;
        writes_start = writes_sent;
        resp_start   = resp_seen;
        load_line();
        run_line(int'(next_random() % 20), int'(next_random() % 4));
        compare_accs("backpressure");
        check_value("backpressure", "write responses",
                    writes_sent - writes_start, resp_seen - resp_start);
        long_hold = 1'b0;
        finish_test("backpressure", errs);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: test/nabp_line_sva.sv
module nabp_line_sva (
    input  logic                   clk,
    input  logic                   reset_n,
    input  nabp_pkg::axil_aw_t     aw,
    input  logic                   awready,
    input  nabp_pkg::axil_w_t      w,
    input  logic                   wready,
    input  logic                   bvalid,
    input  logic                   bready,
    input  nabp_pkg::axil_ar_t     ar,
    input  logic                   arready,
    input  nabp_pkg::axil_r_t      r,
    input  logic                   rready,
    input  logic                   fill_kick,
    input  logic                   write_en,
    input  logic                   line_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // cycles since the last kick, zero when no fill is pending
    logic [4:0] kick_age;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            kick_age <= '0;
        else if (fill_kick)
            kick_age <= 5'd1;
        else if (line_ready)
            kick_age <= '0;
        else if (kick_age != 5'd0)
            kick_age <= kick_age + 1'b1;
    end

    aw_held: assert property (@(posedge clk) disable iff (!reset_n)
        aw.valid && !awready |=> aw.valid)
        else $error("aw valid dropped before awready");

    w_held: assert property (@(posedge clk) disable iff (!reset_n)
        w.valid && !wready |=> w.valid)
        else $error("w valid dropped before wready");

    ar_held: assert property (@(posedge clk) disable iff (!reset_n)
        ar.valid && !arready |=> ar.valid)
        else $error("ar valid dropped before arready");

    b_held: assert property (@(posedge clk) disable iff (!reset_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    r_held: assert property (@(posedge clk) disable iff (!reset_n)
        r.valid && !rready |=> r.valid)
        else $error("rvalid dropped before rready");

    // fill writes sit between the lead cycle and line_ready
    write_in_fill: assert property (@(posedge clk) disable iff (!reset_n)
        write_en |-> kick_age >= 5'd2 && kick_age <= 5'd17)
        else $error("RAM write outside the fill window");

    ready_in_time: assert property (@(posedge clk) disable iff (!reset_n)
        kick_age <= 5'd18)
        else $error("line_ready late after kick");

    ready_after_kick: assert property (@(posedge clk) disable iff (!reset_n)
        line_ready |-> kick_age != 5'd0)
        else $error("line_ready without a kick");

endmodule

// File: verilog/nabp_line_top.sv
`include "nabp_settings.svh"

module nabp_line_top (
    input  logic               clk,
    input  logic               reset_n,
    input  nabp_pkg::axil_aw_t aw,
    output logic               awready,
    input  nabp_pkg::axil_w_t  w,
    output logic               wready,
    output logic               bvalid,
    input  logic               bready,
    input  nabp_pkg::axil_ar_t ar,
    output logic               arready,
    output nabp_pkg::axil_r_t  r,
    input  logic               rready
);
    import nabp_pkg::*;

    logic [`NABP_S_W-1:0]             read_s;
    logic signed [`NABP_SAMPLE_W-1:0] sample;
    logic                             fill_kick;
    logic                             clear;
    logic [`NABP_S_W-1:0]             base;
    logic [1:0]                       step;
    logic                             done;
    pixel_acc_t                       acc;
    logic                             advance;
    logic [`NABP_S_W-2:0]             write_s;
    logic                             write_en;
    logic                             line_ready;
    logic signed [`NABP_FILT_W-1:0]   filt_value;
    logic [`NABP_S_W-2:0]             bp_raddr;
    logic signed [`NABP_FILT_W-1:0]   bp_rdata;

    nabp_host_port i_host_port (
        .clk       (clk),
        .reset_n   (reset_n),
        .aw        (aw),
        .awready   (awready),
        .w         (w),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .ar        (ar),
        .arready   (arready),
        .r         (r),
        .rready    (rready),
        .read_s    (read_s),
        .sample    (sample),
        .fill_kick (fill_kick),
        .clear     (clear),
        .base      (base),
        .step      (step),
        .done      (done),
        .acc       (acc)
    );

    nabp_ramp_filter i_filter (
        .clk     (clk),
        .reset_n (reset_n),
        .kick    (fill_kick),
        .advance (advance),
        .sample  (sample),
        .value   (filt_value)
    );

    nabp_filtered_ram i_fill (
        .clk        (clk),
        .reset_n    (reset_n),
        .fill_kick  (fill_kick),
        .read_s     (read_s),
        .advance    (advance),
        .write_s    (write_s),
        .write_en   (write_en),
        .line_ready (line_ready)
    );

    // port 0 written by the fill, port 1 read by the back-projector
    nabp_dual_port_ram #(
        .DATA_W (`NABP_FILT_W),
        .ADDR_W (`NABP_S_W - 1)
    ) i_ram (
        .clk   (clk),
        .we    (write_en),
        .waddr (write_s),
        .wdata (filt_value),
        .raddr (bp_raddr),
        .rdata (bp_rdata)
    );

    nabp_backprojector i_bp (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (line_ready),
        .clear   (clear),
        .base    (base),
        .step    (step),
        .raddr   (bp_raddr),
        .rdata   (bp_rdata),
        .acc     (acc),
        .done    (done)
    );

endmodule

// File: verilog/nabp_backprojector.sv
`include "nabp_settings.svh"

module nabp_backprojector (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           start,
    input  logic                           clear,
    input  logic [`NABP_S_W-1:0]           base,
    input  logic [1:0]                     step,
    output logic [`NABP_S_W-2:0]           raddr,
    input  logic signed [`NABP_FILT_W-1:0] rdata,
    output nabp_pkg::pixel_acc_t           acc,
    output logic                           done
);
    localparam int P_W   = $clog2(`NABP_PIXELS);
    localparam int A_W   = `NABP_S_W + 1;
    localparam int ACC_W = `NABP_ACC_W;

    logic                    issuing;
    logic [P_W-1:0]          issue_idx;
    logic [A_W-1:0]          addr_full;
    logic                    rd_valid;
    logic [P_W-1:0]          rd_idx;
    logic                    rd_oob;
    logic signed [ACC_W-1:0] addend;

    // pixel i samples base + i * step
    assign addr_full = A_W'(base) + A_W'(issue_idx) * A_W'(step);
    assign raddr     = addr_full[`NABP_S_W-2:0];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            issuing   <= 1'b0;
            issue_idx <= '0;
            rd_valid  <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            if (start)
            begin
                issuing   <= 1'b1;
                issue_idx <= '0;
            end
            else if (issuing)
            begin
                issue_idx <= issue_idx + 1'b1;
                if (issue_idx == P_W'(`NABP_PIXELS - 1))
                    issuing <= 1'b0;
            end
            rd_valid <= issuing;
            done     <= rd_valid && (rd_idx == P_W'(`NABP_PIXELS - 1));
        end
    end

    // pixel tag and out-of-line flag ride along with the read
    always_ff @(posedge clk)
    begin
        rd_idx <= issue_idx;
        rd_oob <= (addr_full >= A_W'(`NABP_LINE_SIZE));
    end

    assign addend = rd_oob ? '0 : ACC_W'(rdata);

    always_ff @(posedge clk)
    begin
        if (!reset_n || clear)
            acc <= '0;
        else if (rd_valid)
            acc[rd_idx] <= acc[rd_idx] + addend;
    end

endmodule

// File: verilog/nabp_dual_port_ram.sv
module nabp_dual_port_ram #(
    parameter int DATA_W = 12,
    parameter int ADDR_W = 4
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [ADDR_W-1:0]        waddr,
    input  logic signed [DATA_W-1:0] wdata,
    input  logic [ADDR_W-1:0]        raddr,
    output logic signed [DATA_W-1:0] rdata
);
    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= wdata;
    end

    // read data one cycle after the address
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

// File: verilog/nabp_filtered_ram.sv
`include "nabp_settings.svh"

module nabp_filtered_ram (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  fill_kick,
    output logic [`NABP_S_W-1:0]  read_s,
    output logic                  advance,
    output logic [`NABP_S_W-2:0]  write_s,
    output logic                  write_en,
    output logic                  line_ready
);
    import nabp_pkg::*;

    localparam int S_W  = `NABP_S_W;
    localparam int LEAD = `NABP_FILTER_ORDER / 2;

    fill_state_e state;
    fill_state_e next_state;

    logic lead_done;
    logic last_write;
    logic read_at_end;

    assign lead_done   = (read_s == S_W'(LEAD - 1));
    assign last_write  = (write_s == (S_W-1)'(`NABP_LINE_SIZE - 1));
    assign read_at_end = (read_s == S_W'(`NABP_LINE_SIZE));

    assign write_en = (state == st_fill);
    assign advance  = (state == st_lead) || (state == st_fill && !read_at_end);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            st_idle:
                if (fill_kick)
                    next_state = st_lead;
            st_lead:
                if (lead_done)
                    next_state = st_fill;
            st_fill:
                if (last_write)
                    next_state = st_idle;
            default:
                next_state = st_idle;
        endcase
    end

    // read runs ahead of write by the lead
    always_ff @(posedge clk)
    begin
        if (!reset_n || state == st_idle)
        begin
            read_s  <= '0;
            write_s <= '0;
        end
        else if (state == st_lead)
            read_s <= read_s + 1'b1;
        else if (state == st_fill)
        begin
            write_s <= write_s + 1'b1;
            if (!read_at_end)
                read_s <= read_s + 1'b1;
        end
    end

    // pulse once the last sample has landed
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            line_ready <= 1'b0;
        else
            line_ready <= (state == st_fill) && last_write;
    end

endmodule

// File: verilog/nabp_ramp_filter.sv
`include "nabp_settings.svh"

module nabp_ramp_filter (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             kick,
    input  logic                             advance,
    input  logic signed [`NABP_SAMPLE_W-1:0] sample,
    output logic signed [`NABP_FILT_W-1:0]   value
);
    localparam int F_W = `NABP_FILT_W;

    // window is prev, centre and the leading sample on the read bus
    logic signed [`NABP_SAMPLE_W-1:0] prev_q;
    logic signed [`NABP_SAMPLE_W-1:0] centre_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n || kick)
        begin
            // cleared window gives the zero left pad
            prev_q   <= '0;
            centre_q <= '0;
        end
        else if (advance)
        begin
            prev_q   <= centre_q;
            centre_q <= sample;
        end
    end

    // ramp kernel -1, 2, -1
    always_comb
    begin
        value = (F_W'(centre_q) <<< 1) - F_W'(prev_q) - F_W'(sample);
    end

endmodule

// File: verilog/nabp_host_port.sv
`include "nabp_settings.svh"

module nabp_host_port (
    input  logic                             clk,
    input  logic                             reset_n,
    input  nabp_pkg::axil_aw_t               aw,
    output logic                             awready,
    input  nabp_pkg::axil_w_t                w,
    output logic                             wready,
    output logic                             bvalid,
    input  logic                             bready,
    input  nabp_pkg::axil_ar_t               ar,
    output logic                             arready,
    output nabp_pkg::axil_r_t                r,
    input  logic                             rready,
    input  logic [`NABP_S_W-1:0]             read_s,
    output logic signed [`NABP_SAMPLE_W-1:0] sample,
    output logic                             fill_kick,
    output logic                             clear,
    output logic [`NABP_S_W-1:0]             base,
    output logic [1:0]                       step,
    input  logic                             done,
    input  nabp_pkg::pixel_acc_t             acc
);
    import nabp_pkg::*;

    localparam int S_W = `NABP_S_W;
    localparam logic [7:0] CMD_ADDR = 8'h40;

    logic signed [`NABP_SAMPLE_W-1:0] line [`NABP_LINE_SIZE];

    ctrl_word_u  word;
    logic        busy;
    logic        bus_held;
    logic        write_take;
    logic        read_take;
    logic        write_fire;
    logic        read_fire;
    logic [31:0] read_data;

    assign word = w.data;

    // one transaction at a time, writes win a tie
    assign bus_held   = awready | arready | bvalid | r.valid;
    assign write_take = aw.valid & w.valid & ~bus_held;
    assign read_take  = ar.valid & ~write_take & ~bus_held;
    assign write_fire = awready & aw.valid & w.valid;
    assign read_fire  = arready & ar.valid;

    // sample feed for the filter, zero past the line end
    assign sample = (read_s < S_W'(`NABP_LINE_SIZE)) ? line[read_s[S_W-2:0]] : '0;

    always_comb
    begin
        read_data = '0;
        if (ar.addr == CMD_ADDR)
            read_data = {31'b0, busy};
        else if (ar.addr[7:5] == 3'b100)
            read_data = 32'($signed(acc[ar.addr[4:2]]));
    end

    // projection line registers
    always_ff @(posedge clk)
    begin
        if (write_fire && aw.addr[7:6] == 2'b00)
            line[aw.addr[5:2]] <= word.sample.value;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            arready   <= 1'b0;
            bvalid    <= 1'b0;
            r         <= '0;
            fill_kick <= 1'b0;
            clear     <= 1'b0;
            busy      <= 1'b0;
            base      <= '0;
            step      <= '0;
        end
        else
        begin
            awready   <= write_take;
            wready    <= write_take;
            arready   <= read_take;
            fill_kick <= 1'b0;
            clear     <= 1'b0;

            if (write_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            if (read_fire)
            begin
                r.valid <= 1'b1;
                r.data  <= read_data;
                r.resp  <= 2'b00;
            end
            else if (rready)
                r.valid <= 1'b0;

            // back-projection finished
            if (done)
                busy <= 1'b0;

            if (write_fire && aw.addr == CMD_ADDR)
            begin
                clear <= word.cmd.clear;
                // kick only honoured when idle
                if (word.cmd.kick && !busy)
                begin
                    fill_kick <= 1'b1;
                    busy      <= 1'b1;
                    base      <= word.cmd.base;
                    step      <= word.cmd.step;
                end
            end
        end
    end

endmodule

// File: verilog/nabp_pkg.sv
`include "nabp_settings.svh"

package nabp_pkg;

    // AXI4-Lite channels
    typedef struct packed {
        logic [7:0] addr;
        logic       valid;
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic        valid;
    } axil_w_t;

    typedef struct packed {
        logic [7:0] addr;
        logic       valid;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        valid;
    } axil_r_t;

    // write word as seen at the sample addresses
    typedef struct packed {
        logic [31:`NABP_SAMPLE_W]             unused;
        logic signed [`NABP_SAMPLE_W-1:0]     value;
    } sample_view_t;

    // write word as seen at the command address
    typedef struct packed {
        logic [31:`NABP_S_W+4]  unused;
        logic [`NABP_S_W-1:0]   base;
        logic [1:0]             step;
        logic                   clear;
        logic                   kick;
    } cmd_view_t;

    typedef union packed {
        sample_view_t sample;
        cmd_view_t    cmd;
    } ctrl_word_u;

    typedef enum logic [1:0] {
        st_idle,
        st_lead,
        st_fill
    } fill_state_e;

    typedef logic [`NABP_PIXELS-1:0][`NABP_ACC_W-1:0] pixel_acc_t;

endpackage

// File: verilog/nabp_settings.svh
`ifndef NABP_SETTINGS_SVH
`define NABP_SETTINGS_SVH

// samples in one projection line
`define NABP_LINE_SIZE 16
// sample index, wide enough to hold the line size itself
`define NABP_S_W 5

// signed data widths
`define NABP_SAMPLE_W 8
`define NABP_FILT_W 12
`define NABP_ACC_W 16

// pixels on one row
`define NABP_PIXELS 8

// ramp kernel order, read index leads by half of it
`define NABP_FILTER_ORDER 2

`endif
